/* verilog/axi_link_pkg.sv */
// AXI read link package
// Field types, PHY word bit positions and link constants for the read master

package axi_link_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // AXI field widths
  typedef logic [3:0]  id_t;
  typedef logic [31:0] addr_t;
  typedef logic [7:0]  len_t;
  typedef logic [2:0]  size_t;
  typedef logic [1:0]  burst_t;
  typedef logic [31:0] data_t;
  typedef logic [1:0]  resp_t;
  typedef logic [7:0]  credit_t;

  // One word on the PHY link
  typedef logic [79:0] phy_word_t;

  // Packed AR request, id in the low bits and addr at the top
  typedef logic [48:0] ar_pkt_t;
  // Packed R beat, id in the low bits and resp at the top
  typedef logic [38:0] r_pkt_t;

  typedef enum logic [1:0] {
    LINK_OFFLINE,
    LINK_WAIT,
    LINK_ONLINE
  } link_state_t;

  ////////////////////////////////////////////////////////////////////////////
  // Link constants
  localparam int LINK_DELAY   = 4;
  localparam int R_FIFO_DEPTH = 8;

  // Transmit word layout
  localparam int TX_PUSH_BIT   = 0;
  localparam int TX_AR_LSB     = 1;
  localparam int TX_CREDIT_BIT = 50;

  // Receive word layout
  localparam int RX_PUSH_BIT   = 0;
  localparam int RX_R_LSB      = 1;
  localparam int RX_CREDIT_BIT = 40;

endpackage

/* verilog/link_ctrl.sv */
// Link control
// Online bring-up FSM, AR transmit credit counter and the AR send decision

`timescale 1ns/1ns

module link_ctrl (
  input  logic                  clk_wr,
  input  logic                  rst,
  input  logic                  tx_online,
  input  logic                  rx_online,
  input  axi_link_pkg::credit_t init_ar_credit,
  input  logic                  ar_entry_valid,
  input  logic                  rx_ar_credit,
  output logic                  ar_send,
  output logic                  link_up
);

  axi_link_pkg::link_state_t state;
  logic [$clog2(axi_link_pkg::LINK_DELAY)-1:0] delay_cnt;
  axi_link_pkg::credit_t ar_credit;
  logic both_online;
  logic enter_online;

  assign both_online  = tx_online & rx_online;
  assign enter_online = (state == axi_link_pkg::LINK_WAIT) && both_online &&
                        (delay_cnt == axi_link_pkg::LINK_DELAY - 1);

  ////////////////////////////////////////////////////////////////////////////
  // Bring-up FSM
  always_ff @(posedge clk_wr) begin
    if (rst) begin
      state     <= axi_link_pkg::LINK_OFFLINE;
      delay_cnt <= '0;
    end else if (!both_online) begin
      // Either side dropping takes the link down at once
      state     <= axi_link_pkg::LINK_OFFLINE;
      delay_cnt <= '0;
    end else begin
      case (state)
        axi_link_pkg::LINK_OFFLINE: begin
          state     <= axi_link_pkg::LINK_WAIT;
          delay_cnt <= '0;
        end
        axi_link_pkg::LINK_WAIT: begin
          if (enter_online) begin
            state <= axi_link_pkg::LINK_ONLINE;
          end else begin
            delay_cnt <= delay_cnt + 1'b1;
          end
        end
        default: state <= axi_link_pkg::LINK_ONLINE;
      endcase
    end
  end

  assign link_up = (state == axi_link_pkg::LINK_ONLINE);

  // Held entry goes out only when online with credit left
  assign ar_send = link_up && (ar_credit != '0) && ar_entry_valid;

  ////////////////////////////////////////////////////////////////////////////
  // AR credit counter
  always_ff @(posedge clk_wr) begin
    if (rst) begin
      ar_credit <= '0;
    end else if (enter_online) begin
      ar_credit <= init_ar_credit;
    end else if (link_up) begin
      case ({ar_send, rx_ar_credit})
        2'b10:   ar_credit <= ar_credit - 8'd1;
        2'b01:   ar_credit <= ar_credit + 8'd1;
        default: ar_credit <= ar_credit;
      endcase
    end
  end

endmodule

/* verilog/ar_transmit.sv */
// AR transmit stage
// One-entry holding register that packs an accepted AR request for the link

`timescale 1ns/1ns

module ar_transmit (
  input  logic                  clk_wr,
  input  logic                  rst,
  input  axi_link_pkg::id_t     user_arid,
  input  axi_link_pkg::addr_t   user_araddr,
  input  axi_link_pkg::len_t    user_arlen,
  input  axi_link_pkg::size_t   user_arsize,
  input  axi_link_pkg::burst_t  user_arburst,
  input  logic                  user_arvalid,
  output logic                  user_arready,
  input  logic                  ar_send,
  output logic                  ar_entry_valid,
  output axi_link_pkg::ar_pkt_t ar_pkt
);

  logic ar_accept;

  // Only one request in flight, so ready is simply an empty entry
  assign user_arready = ~ar_entry_valid;
  assign ar_accept    = user_arvalid & user_arready;

  ////////////////////////////////////////////////////////////////////////////
  // Entry state
  always_ff @(posedge clk_wr) begin
    if (rst) begin
      ar_entry_valid <= 1'b0;
    end else if (ar_accept) begin
      ar_entry_valid <= 1'b1;
    end else if (ar_send) begin
      ar_entry_valid <= 1'b0;
    end
  end

  // Request payload
  // Field order from bit 0: id, size, len, burst, addr
  always_ff @(posedge clk_wr) begin
    if (ar_accept) begin
      ar_pkt <= {user_araddr, user_arburst, user_arlen, user_arsize, user_arid};
    end
  end

endmodule

/* verilog/r_receive.sv */
// R receive FIFO
// Buffers R beats from the link, presents the head on the user R channel
// and returns one credit per beat taken

`timescale 1ns/1ns

module r_receive (
  input  logic                 clk_wr,
  input  logic                 rst,
  input  logic                 link_up,
  input  logic                 rx_r_push,
  input  axi_link_pkg::r_pkt_t rx_r_pkt,
  output axi_link_pkg::id_t    user_rid,
  output axi_link_pkg::data_t  user_rdata,
  output logic                 user_rlast,
  output axi_link_pkg::resp_t  user_rresp,
  output logic                 user_rvalid,
  input  logic                 user_rready,
  output logic                 r_credit_return
);

  axi_link_pkg::r_pkt_t fifo_mem [axi_link_pkg::R_FIFO_DEPTH];
  logic [$clog2(axi_link_pkg::R_FIFO_DEPTH)-1:0] wr_ptr;
  logic [$clog2(axi_link_pkg::R_FIFO_DEPTH)-1:0] rd_ptr;
  logic [$clog2(axi_link_pkg::R_FIFO_DEPTH):0]   fill;
  logic fifo_full;
  logic push;
  logic pop;

  assign fifo_full = (fill == axi_link_pkg::R_FIFO_DEPTH);

  // Beats arriving while full or offline are dropped
  assign push = rx_r_push & link_up & ~fifo_full;
  assign pop  = user_rvalid & user_rready;

  ////////////////////////////////////////////////////////////////////////////
  // Pointers and fill level
  always_ff @(posedge clk_wr) begin
    if (rst) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      fill   <= '0;
    end else begin
      if (push) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      case ({push, pop})
        2'b10:   fill <= fill + 1'b1;
        2'b01:   fill <= fill - 1'b1;
        default: fill <= fill;
      endcase
    end
  end

  // Storage
  always_ff @(posedge clk_wr) begin
    if (push) begin
      fifo_mem[wr_ptr] <= rx_r_pkt;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // User side
  assign user_rvalid = (fill != '0);

  // Field order from bit 0: id, data, last, resp
  assign {user_rresp, user_rlast, user_rdata, user_rid} = fifo_mem[rd_ptr];

  // Every taken beat frees one slot at the far end
  assign r_credit_return = pop;

endmodule

/* verilog/phy_framer.sv */
// PHY framer
// Builds the registered transmit PHY word and splits the received PHY word

`timescale 1ns/1ns

module phy_framer (
  input  logic                     clk_wr,
  input  logic                     rst,
  input  logic                     ar_send,
  input  axi_link_pkg::ar_pkt_t    ar_pkt,
  input  logic                     r_credit_return,
  output axi_link_pkg::phy_word_t  tx_phy,
  input  axi_link_pkg::phy_word_t  rx_phy,
  output logic                     rx_r_push,
  output axi_link_pkg::r_pkt_t     rx_r_pkt,
  output logic                     rx_ar_credit
);

  axi_link_pkg::phy_word_t tx_next;

  ////////////////////////////////////////////////////////////////////////////
  // Transmit word
  always_comb begin
    tx_next = '0;
    tx_next[axi_link_pkg::TX_PUSH_BIT]   = ar_send;
    tx_next[axi_link_pkg::TX_CREDIT_BIT] = r_credit_return;
    // AR field stays zero on idle words
    if (ar_send) begin
      tx_next[axi_link_pkg::TX_AR_LSB +: $bits(axi_link_pkg::ar_pkt_t)] = ar_pkt;
    end
  end

  always_ff @(posedge clk_wr) begin
    if (rst) begin
      tx_phy <= '0;
    end else begin
      tx_phy <= tx_next;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Receive word
  assign rx_r_push    = rx_phy[axi_link_pkg::RX_PUSH_BIT];
  assign rx_r_pkt     = rx_phy[axi_link_pkg::RX_R_LSB +: $bits(axi_link_pkg::r_pkt_t)];
  assign rx_ar_credit = rx_phy[axi_link_pkg::RX_CREDIT_BIT];

endmodule

/* verilog/axi_read_master_top.sv */
// AXI read packet master
// Carries AR requests and R beats over an 80-bit credited PHY link

`timescale 1ns/1ns

module axi_read_master_top (
  input  logic                    clk_wr,
  input  logic                    rst,

  // Link control
  input  logic                    tx_online,
  input  logic                    rx_online,
  input  axi_link_pkg::credit_t   init_ar_credit,

  // PHY words
  output axi_link_pkg::phy_word_t tx_phy,
  input  axi_link_pkg::phy_word_t rx_phy,

  // AR channel
  input  axi_link_pkg::id_t       user_arid,
  input  axi_link_pkg::addr_t     user_araddr,
  input  axi_link_pkg::len_t      user_arlen,
  input  axi_link_pkg::size_t     user_arsize,
  input  axi_link_pkg::burst_t    user_arburst,
  input  logic                    user_arvalid,
  output logic                    user_arready,

  // R channel
  output axi_link_pkg::id_t       user_rid,
  output axi_link_pkg::data_t     user_rdata,
  output logic                    user_rlast,
  output axi_link_pkg::resp_t     user_rresp,
  output logic                    user_rvalid,
  input  logic                    user_rready
);

  ////////////////////////////////////////////////////////////////////////////
  // Internal wires
  logic                  ar_send;
  logic                  ar_entry_valid;
  axi_link_pkg::ar_pkt_t ar_pkt;
  logic                  link_up;
  logic                  rx_r_push;
  axi_link_pkg::r_pkt_t  rx_r_pkt;
  logic                  rx_ar_credit;
  logic                  r_credit_return;

  link_ctrl link_ctrl_i (
    .clk_wr         (clk_wr),
    .rst            (rst),
    .tx_online      (tx_online),
    .rx_online      (rx_online),
    .init_ar_credit (init_ar_credit),
    .ar_entry_valid (ar_entry_valid),
    .rx_ar_credit   (rx_ar_credit),
    .ar_send        (ar_send),
    .link_up        (link_up)
  );

  ar_transmit ar_transmit_i (
    .clk_wr         (clk_wr),
    .rst            (rst),
    .user_arid      (user_arid),
    .user_araddr    (user_araddr),
    .user_arlen     (user_arlen),
    .user_arsize    (user_arsize),
    .user_arburst   (user_arburst),
    .user_arvalid   (user_arvalid),
    .user_arready   (user_arready),
    .ar_send        (ar_send),
    .ar_entry_valid (ar_entry_valid),
    .ar_pkt         (ar_pkt)
  );

  r_receive r_receive_i (
    .clk_wr          (clk_wr),
    .rst             (rst),
    .link_up         (link_up),
    .rx_r_push       (rx_r_push),
    .rx_r_pkt        (rx_r_pkt),
    .user_rid        (user_rid),
    .user_rdata      (user_rdata),
    .user_rlast      (user_rlast),
    .user_rresp      (user_rresp),
    .user_rvalid     (user_rvalid),
    .user_rready     (user_rready),
    .r_credit_return (r_credit_return)
  );

  phy_framer phy_framer_i (
    .clk_wr          (clk_wr),
    .rst             (rst),
    .ar_send         (ar_send),
    .ar_pkt          (ar_pkt),
    .r_credit_return (r_credit_return),
    .tx_phy          (tx_phy),
    .rx_phy          (rx_phy),
    .rx_r_push       (rx_r_push),
    .rx_r_pkt        (rx_r_pkt),
    .rx_ar_credit    (rx_ar_credit)
  );

endmodule

/* bench/tb_clock.sv */
// Testbench clock
// Free-running clock with a 40 ns period

`timescale 1ns/1ns

module tb_clock (
  output logic clk
);

  localparam int HALF_PERIOD = 20;

  initial begin
    clk = 1'b0;
    forever #HALF_PERIOD clk = ~clk;
  end

endmodule

/* bench/tb_axi_read_master.sv */
// AXI read master testbench
// Offers AR requests and R beats over the PHY link and checks both directions

`timescale 1ns/1ns

module tb_axi_read_master;

  localparam int TIMEOUT = 200;

  logic                    clk;
  logic                    rst;
  logic                    tx_online;
  logic                    rx_online;
  axi_link_pkg::credit_t   init_ar_credit;
  axi_link_pkg::phy_word_t tx_phy;
  axi_link_pkg::phy_word_t rx_phy;
  axi_link_pkg::id_t       user_arid;
  axi_link_pkg::addr_t     user_araddr;
  axi_link_pkg::len_t      user_arlen;
  axi_link_pkg::size_t     user_arsize;
  axi_link_pkg::burst_t    user_arburst;
  logic                    user_arvalid;
  logic                    user_arready;
  axi_link_pkg::id_t       user_rid;
  axi_link_pkg::data_t     user_rdata;
  logic                    user_rlast;
  axi_link_pkg::resp_t     user_rresp;
  logic                    user_rvalid;
  logic                    user_rready;

  // Scoreboard
  axi_link_pkg::ar_pkt_t ar_exp_q[$];
  axi_link_pkg::r_pkt_t  r_exp_q[$];
  axi_link_pkg::ar_pkt_t ar_exp;
  axi_link_pkg::r_pkt_t  r_exp;
  int ar_accepts;
  int tx_pushes;
  int tx_credits;
  int r_sent;
  int r_handshakes;
  int checks;
  int errors;
  int timeouts;
  logic ar_offers_done;

  tb_clock clock_gen (.clk(clk));

  axi_read_master_top uut (.clk_wr(clk), .*);

  ////////////////////////////////////////////////////////////////////////////
  // Reference functions

  // AR field with id, size, len, burst and addr from bit 0 upward
  function automatic axi_link_pkg::ar_pkt_t pack_ar(input axi_link_pkg::id_t id,
      input axi_link_pkg::addr_t addr, input axi_link_pkg::len_t len,
      input axi_link_pkg::size_t size, input axi_link_pkg::burst_t burst);
    axi_link_pkg::ar_pkt_t pkt;
    pkt = '0;
    pkt[3:0]   = id;
    pkt[6:4]   = size;
    pkt[14:7]  = len;
    pkt[16:15] = burst;
    pkt[48:17] = addr;
    return pkt;
  endfunction

  // Received word carrying one R beat with id, data, last and resp from the low end
  function automatic axi_link_pkg::phy_word_t pack_r(input axi_link_pkg::id_t id,
      input axi_link_pkg::data_t data, input logic last, input axi_link_pkg::resp_t resp);
    axi_link_pkg::phy_word_t word;
    word = '0;
    word[axi_link_pkg::RX_PUSH_BIT]          = 1'b1;
    word[axi_link_pkg::RX_R_LSB +: 4]        = id;
    word[axi_link_pkg::RX_R_LSB + 4 +: 32]   = data;
    word[axi_link_pkg::RX_R_LSB + 36]        = last;
    word[axi_link_pkg::RX_R_LSB + 37 +: 2]   = resp;
    return word;
  endfunction

  task automatic check_value(input string name, input logic [79:0] got,
      input logic [79:0] exp);
    checks++;
    assert (got === exp) else begin
      errors++;
      $display("error at %0t ns: %s is %0h, expected %0h", $time, name, got, exp);
    end
  endtask

  task automatic report_failure(input string what);
    errors++;
    $display("failure at %0t ns: %s", $time, what);
  endtask

  task automatic report_timeout(input string what);
    timeouts++;
    $display("timeout at %0t ns: waited too long for %s", $time, what);
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Compares registered outputs before the edge updates them
  always @(posedge clk) begin
    if (!rst) begin
      if (user_arvalid && user_arready) begin
        ar_exp_q.push_back(pack_ar(user_arid, user_araddr, user_arlen, user_arsize,
                                   user_arburst));
        ar_accepts++;
      end
      check_value("tx_phy unused bits", tx_phy[79:axi_link_pkg::TX_CREDIT_BIT+1], '0);
      if (tx_phy[axi_link_pkg::TX_PUSH_BIT]) begin
        tx_pushes++;
        if (ar_exp_q.size() == 0) begin
          report_failure("AR push on tx_phy with no accepted request");
        end else begin
          ar_exp = ar_exp_q.pop_front();
          check_value("tx_phy AR field", tx_phy[axi_link_pkg::TX_AR_LSB +: 49], ar_exp);
        end
      end else begin
        check_value("tx_phy idle AR field", tx_phy[axi_link_pkg::TX_AR_LSB +: 49], '0);
      end
      if (tx_phy[axi_link_pkg::TX_CREDIT_BIT]) begin
        tx_credits++;
      end
      if (user_rvalid && user_rready) begin
        r_handshakes++;
        if (r_exp_q.size() == 0) begin
          report_failure("R handshake with no beat outstanding");
        end else begin
          r_exp = r_exp_q.pop_front();
          check_value("user_rid", user_rid, r_exp[3:0]);
          check_value("user_rdata", user_rdata, r_exp[35:4]);
          check_value("user_rlast", user_rlast, r_exp[36]);
          check_value("user_rresp", user_rresp, r_exp[38:37]);
        end
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Stimulus tasks called on a falling edge

  task automatic offer_random_ar();
    int n;
    int start;
    logic [31:0] rnd;
    rnd = $urandom();
    start = ar_accepts;
    user_arid    = rnd[3:0];
    user_arsize  = rnd[6:4];
    user_arlen   = rnd[14:7];
    user_arburst = rnd[16:15];
    user_araddr  = $urandom();
    user_arvalid = 1'b1;
    n = 0;
    while (ar_accepts == start && n < TIMEOUT) begin
      @(negedge clk);
      n++;
    end
    user_arvalid = 1'b0;
    if (ar_accepts == start) report_timeout("AR acceptance");
  endtask

  task automatic wait_pushes(input int target, output int cycles);
    cycles = 0;
    while (tx_pushes < target && cycles < TIMEOUT) begin
      @(negedge clk);
      cycles++;
    end
    if (tx_pushes < target) report_timeout("an AR push on tx_phy");
  endtask

  task automatic send_ar_credit();
    rx_phy = '0;
    rx_phy[axi_link_pkg::RX_CREDIT_BIT] = 1'b1;
    @(negedge clk);
    rx_phy = '0;
  endtask

  task automatic send_r_beats(input int count);
    int sent;
    int n;
    logic [31:0] rnd;
    axi_link_pkg::phy_word_t word;
    sent = 0;
    n = 0;
    while (sent < count && n < TIMEOUT) begin
      @(negedge clk);
      n++;
      rnd = $urandom();
      user_rready = rnd[0];
      rx_phy = '0;
      // Far end sends only while it still holds a credit
      if (rnd[1] && (r_sent - tx_credits) < axi_link_pkg::R_FIFO_DEPTH) begin
        word = pack_r(rnd[7:4], $urandom(), rnd[8], rnd[10:9]);
        rx_phy = word;
        r_exp_q.push_back(word[axi_link_pkg::RX_R_LSB +: 39]);
        r_sent++;
        sent++;
      end
    end
    @(negedge clk);
    rx_phy = '0;
    if (sent < count) report_timeout("R credits to send beats");
  endtask

  task automatic drain_r();
    int n;
    logic [31:0] rnd;
    n = 0;
    while ((r_handshakes < r_sent || tx_credits < r_handshakes) && n < TIMEOUT) begin
      @(negedge clk);
      n++;
      rnd = $urandom();
      user_rready = rnd[0];
    end
    user_rready = 1'b0;
    if (r_handshakes < r_sent || tx_credits < r_handshakes) report_timeout("R beats to drain");
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Test sequence
  initial begin
    int cycles;
    int base;
    void'($urandom(22));
    rst = 1'b1;
    tx_online = 1'b0;
    rx_online = 1'b0;
    init_ar_credit = '0;
    rx_phy = '0;
    user_arid = '0;
    user_araddr = '0;
    user_arlen = '0;
    user_arsize = '0;
    user_arburst = '0;
    user_arvalid = 1'b0;
    user_rready = 1'b0;
    ar_offers_done = 1'b0;
    repeat (2) @(negedge clk);
    rst = 1'b0;

    // Reset state
    check_value("tx_phy", tx_phy, '0);
    check_value("user_arready", user_arready, 1'b1);
    check_value("user_rvalid", user_rvalid, 1'b0);

    // Online gating
    init_ar_credit = 8'd4;
    offer_random_ar();
    repeat (10) @(negedge clk);
    checks++;
    assert (tx_pushes == 0) else report_failure("AR push while the link was offline");
    tx_online = 1'b1;
    rx_online = 1'b1;
    wait_pushes(1, cycles);
    checks++;
    assert (cycles >= axi_link_pkg::LINK_DELAY)
      else report_failure("AR push came before the bring-up delay ended");

    // Credit limit with two credits against four requests
    tx_online = 1'b0;
    init_ar_credit = 8'd2;
    repeat (2) @(negedge clk);
    base = tx_pushes;
    fork
      begin
        repeat (4) offer_random_ar();
        ar_offers_done = 1'b1;
      end
    join_none
    tx_online = 1'b1;
    wait_pushes(base + 2, cycles);
    repeat (20) @(negedge clk);
    checks++;
    assert (tx_pushes == base + 2) else report_failure("more AR pushes than credits");
    for (int i = 1; i <= 2; i++) begin
      send_ar_credit();
      wait_pushes(base + 2 + i, cycles);
      repeat (10) @(negedge clk);
      checks++;
      assert (tx_pushes == base + 2 + i)
        else report_failure("one AR credit released other than one push");
    end
    cycles = 0;
    while (!ar_offers_done && cycles < TIMEOUT) begin
      @(negedge clk);
      cycles++;
    end
    if (!ar_offers_done) report_timeout("the AR offers to finish");
    checks++;
    assert (ar_exp_q.size() == 0) else report_failure("accepted AR requests never pushed");

    // R delivery under random back-pressure
    send_r_beats(8);
    drain_r();
    checks++;
    assert (r_handshakes == 8 && r_exp_q.size() == 0)
      else report_failure("R beats lost or duplicated");

    // R credit return over 20 beats in total
    send_r_beats(12);
    drain_r();
    check_value("R credit bits on tx_phy", tx_credits, r_handshakes);
    check_value("R handshakes", r_handshakes, 20);

    $display("checks %0d, errors %0d, timeouts %0d", checks, errors, timeouts);
    if (errors == 0 && timeouts == 0) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  end

endmodule

/* project.f */
verilog/axi_link_pkg.sv
verilog/link_ctrl.sv
verilog/ar_transmit.sv
verilog/r_receive.sv
verilog/phy_framer.sv
verilog/axi_read_master_top.sv
bench/tb_clock.sv
bench/tb_axi_read_master.sv

/* Makefile */
# Verilator build and run of the AXI read master testbench

VERILATOR ?= verilator
TOP       ?= tb_axi_read_master
FILELIST  ?= project.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -q "All tests passed"

clean:
	rm -rf $(OBJ_DIR)
